/* design/laser_link_pkg.sv */
`default_nettype none

package laser_link_pkg;

    // One byte on the laser line or at the host queues
    typedef logic [7:0] link_byte_t;

    typedef enum logic [2:0] {
        TAG_START,
        TAG_DATA,
        TAG_STOP,
        TAG_ERROR,
        TAG_DONE
    } tag_t;

    localparam int NUM_TAGS = 5;

    // Handshake bytes
    localparam link_byte_t HS_REQUEST = 8'hAA;
    localparam link_byte_t HS_ACK     = 8'h10;

    // Tag words go out most significant byte first
    // First bytes must stay unique across all tags
    localparam logic [31:0] TAG_WORD_START = 32'hC1C2C3C4;
    localparam logic [31:0] TAG_WORD_DATA  = 32'hD1D2D3D4;
    localparam logic [31:0] TAG_WORD_STOP  = 32'h51525354;
    localparam logic [31:0] TAG_WORD_ERROR = 32'hB1B2B3B4;
    localparam logic [31:0] TAG_WORD_DONE  = 32'hA1A2A3A4;

    function automatic logic [31:0] tag_word(input tag_t kind);
        case (kind)
            TAG_START: return TAG_WORD_START;
            TAG_DATA:  return TAG_WORD_DATA;
            TAG_STOP:  return TAG_WORD_STOP;
            TAG_ERROR: return TAG_WORD_ERROR;
            default:   return TAG_WORD_DONE;
        endcase
    endfunction

endpackage

`default_nettype wire

/* design/byte_queue_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface byte_queue_if;

    logic       push;
    logic [7:0] push_data;
    logic       full;
    logic       pop;
    logic [7:0] pop_data;
    logic       empty;

    modport writer (
        output push,
        output push_data,
        input  full
    );

    modport reader (
        output pop,
        input  pop_data,
        input  empty
    );

    modport fifo (
        input  push,
        input  push_data,
        input  pop,
        output full,
        output pop_data,
        output empty
    );

endinterface

`default_nettype wire

/* design/byte_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module byte_fifo
    import laser_link_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clock,
    input  logic       reset,
    byte_queue_if.fifo queue
);

    localparam int PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

    link_byte_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               do_push;
    logic               do_pop;

    // Pointers wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign queue.full     = (count == COUNT_W'(FIFO_DEPTH));
    assign queue.empty    = (count == '0);
    assign queue.pop_data = mem[rd_ptr];

    // Illegal requests are simply ignored
    assign do_push = queue.push && !queue.full;
    assign do_pop  = queue.pop && !queue.empty;

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= queue.push_data;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/laser_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

module laser_serializer
    import laser_link_pkg::*;
#(
    parameter int CLOCKS_PER_BIT = 16
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       send,
    input  link_byte_t data,
    output logic       busy,
    output logic       done,
    output logic       laser_out
);

    localparam int CNT_W = (CLOCKS_PER_BIT > 1) ? $clog2(CLOCKS_PER_BIT) : 1;

    logic [CNT_W-1:0] clk_count;
    logic [3:0]       bit_count;
    logic [8:0]       shift;
    logic             bit_end;

    assign bit_end = busy && (clk_count == CNT_W'(CLOCKS_PER_BIT - 1));

    // Data bits then stop bit, LSB first
    always_ff @(posedge clock) begin
        if (!busy && send) begin
            shift <= {1'b1, data};
        end else if (bit_end) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            laser_out <= 1'b1;
            clk_count <= '0;
            bit_count <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (send) begin
                    // Start bit goes out right away
                    busy      <= 1'b1;
                    laser_out <= 1'b0;
                    clk_count <= '0;
                    bit_count <= '0;
                end
            end else if (bit_end) begin
                clk_count <= '0;
                if (bit_count == 4'd9) begin
                    busy      <= 1'b0;
                    done      <= 1'b1;
                    laser_out <= 1'b1;
                end else begin
                    laser_out <= shift[0];
                    bit_count <= bit_count + 1'b1;
                end
            end else begin
                clk_count <= clk_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/laser_deserializer.sv */
`timescale 1ns/10ps
`default_nettype none

module laser_deserializer
    import laser_link_pkg::*;
#(
    parameter int CLOCKS_PER_BIT = 16
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       laser_in,
    output link_byte_t data,
    output logic       valid
);

    localparam int CNT_W    = (CLOCKS_PER_BIT > 1) ? $clog2(CLOCKS_PER_BIT) : 1;
    localparam int HALF_BIT = CLOCKS_PER_BIT / 2;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             line_meta;
    logic             line_sync;
    logic             line_prev;
    logic [CNT_W-1:0] clk_count;
    logic [2:0]       bit_count;
    logic             bit_end;
    link_byte_t       shift;

    assign bit_end = (clk_count == CNT_W'(CLOCKS_PER_BIT - 1));
    assign data    = shift;

    // Two-flop synchronizer plus edge history, idle high
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            line_meta <= 1'b1;
            line_sync <= 1'b1;
            line_prev <= 1'b1;
        end else begin
            line_meta <= laser_in;
            line_sync <= line_meta;
            line_prev <= line_sync;
        end
    end

    // LSB arrives first so shift toward bit 0
    always_ff @(posedge clock) begin
        if (state == RX_DATA && bit_end) begin
            shift <= {line_sync, shift[7:1]};
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state     <= RX_IDLE;
            clk_count <= '0;
            bit_count <= '0;
            valid     <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (line_prev && !line_sync) begin
                        state     <= RX_START;
                        clk_count <= '0;
                    end
                end
                RX_START: begin
                    // Recheck at mid start bit to reject glitches
                    if (clk_count == CNT_W'(HALF_BIT - 1)) begin
                        clk_count <= '0;
                        bit_count <= '0;
                        state     <= line_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_count <= '0;
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        // Framing error drops the byte
                        clk_count <= '0;
                        valid     <= line_sync;
                        state     <= RX_IDLE;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/frame_tag_detector.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_tag_detector
    import laser_link_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  link_byte_t data,
    input  logic       valid,
    output logic       tag_seen,
    output tag_t       tag_kind
);

    typedef enum logic [1:0] {
        WAIT_FIRST,
        SAW_ONE,
        SAW_TWO,
        SAW_THREE
    } match_state_t;

    match_state_t state;
    match_state_t next_state;
    tag_t         candidate;
    tag_t         first_kind;
    logic         first_hit;
    logic [31:0]  cand_word;
    link_byte_t   expected;

    assign cand_word = tag_word(candidate);
    assign tag_kind  = candidate;

    // First bytes are unique so at most one tag hits
    always_comb begin : first_lookup
        logic [31:0] word;
        first_hit  = 1'b0;
        first_kind = TAG_START;
        for (int i = 0; i < NUM_TAGS; i++) begin
            word = tag_word(tag_t'(i));
            if (data == word[31:24]) begin
                first_hit  = 1'b1;
                first_kind = tag_t'(i);
            end
        end
    end

    always_comb begin
        case (state)
            SAW_ONE: expected = cand_word[23:16];
            SAW_TWO: expected = cand_word[15:8];
            default: expected = cand_word[7:0];
        endcase
    end

    always_comb begin
        next_state = state;
        tag_seen   = 1'b0;
        if (valid) begin
            if (state == WAIT_FIRST) begin
                if (first_hit) begin
                    next_state = SAW_ONE;
                end
            end else if (data != expected) begin
                // Mismatching byte is not retried as a first byte
                next_state = WAIT_FIRST;
            end else if (state == SAW_THREE) begin
                tag_seen   = 1'b1;
                next_state = WAIT_FIRST;
            end else begin
                next_state = match_state_t'(state + 1'b1);
            end
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state     <= WAIT_FIRST;
            candidate <= TAG_START;
        end else begin
            state <= next_state;
            if (valid && state == WAIT_FIRST && first_hit) begin
                candidate <= first_kind;
            end
        end
    end

endmodule

`default_nettype wire

/* design/link_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module link_controller
    import laser_link_pkg::*;
#(
    parameter int CLOCKS_PER_BIT  = 16,
    parameter int MAX_RX_BYTES    = 1024,
    parameter int HS_TIMEOUT_BITS = 1024
) (
    input  logic         clock,
    input  logic         reset,
    byte_queue_if.reader tx_queue,
    byte_queue_if.writer rx_queue,
    output logic         send,
    output link_byte_t   send_data,
    input  logic         tx_busy,
    input  logic         tx_done,
    input  link_byte_t   rx_data,
    input  logic         rx_valid,
    input  logic         tag_seen,
    input  tag_t         tag_kind
);

    // Timer limits in clock cycles
    localparam int ALIGN_CYCLES   = 12 * CLOCKS_PER_BIT;
    localparam int GAP_CYCLES     = 16 * CLOCKS_PER_BIT;
    localparam int SILENCE_CYCLES = 12 * CLOCKS_PER_BIT;
    localparam int HS_CYCLES      = HS_TIMEOUT_BITS * CLOCKS_PER_BIT;
    localparam int TIMER_MAX      = (HS_CYCLES > GAP_CYCLES) ? HS_CYCLES : GAP_CYCLES;
    localparam int TIMER_W        = $clog2(TIMER_MAX + 1);
    localparam int COUNT_W        = $clog2(MAX_RX_BYTES + 1);

    typedef enum logic [3:0] {
        IDLE,
        HS_TX_REQUEST,
        HS_TX_ALIGN,
        TX_SEND,
        TX_WAIT,
        TX_GAP,
        HS_RX_REPLY,
        RX_LOAD_TAG,
        RX_RECEIVE
    } state_t;

    state_t              state;
    state_t              next_state;
    logic [TIMER_W-1:0]  timer;
    logic                timer_clear;
    logic [COUNT_W-1:0]  byte_count;
    logic                count_inc;
    logic [1:0]          tag_index;
    logic                tag_advance;
    logic                tag_load;
    tag_t                tag_latched;
    logic [3:0][7:0]     tag_bytes;
    logic                saw_request;
    logic                saw_ack;

    assign tag_bytes   = tag_word(tag_latched);
    assign saw_request = rx_valid && (rx_data == HS_REQUEST);
    assign saw_ack     = rx_valid && (rx_data == HS_ACK);

    always_comb begin
        next_state          = state;
        send                = 1'b0;
        send_data           = HS_REQUEST;
        tx_queue.pop        = 1'b0;
        rx_queue.push       = 1'b0;
        rx_queue.push_data  = rx_data;
        timer_clear         = 1'b0;
        count_inc           = 1'b0;
        tag_advance         = 1'b0;
        tag_load            = 1'b0;

        case (state)
            IDLE: begin
                // Outgoing data wins over a far-end request
                if (!tx_queue.empty) begin
                    next_state = HS_TX_REQUEST;
                end else if (saw_request) begin
                    next_state = HS_RX_REPLY;
                    send       = !tx_busy;
                    send_data  = HS_ACK;
                end
            end
            HS_TX_REQUEST: begin
                // Keep asking until the far end acknowledges
                send = !tx_busy && !saw_ack;
                if (saw_ack) begin
                    next_state = HS_TX_ALIGN;
                end
            end
            HS_TX_ALIGN: begin
                if (timer >= TIMER_W'(ALIGN_CYCLES) && !tx_busy) begin
                    next_state = TX_SEND;
                end
            end
            TX_SEND: begin
                if (tx_queue.empty) begin
                    next_state = TX_GAP;
                end else if (!tx_busy) begin
                    send         = 1'b1;
                    send_data    = tx_queue.pop_data;
                    tx_queue.pop = 1'b1;
                    next_state   = TX_WAIT;
                end
            end
            TX_WAIT: begin
                if (tx_done) begin
                    next_state = TX_SEND;
                end
            end
            TX_GAP: begin
                if (timer >= TIMER_W'(GAP_CYCLES)) begin
                    next_state = IDLE;
                end
            end
            HS_RX_REPLY: begin
                if (saw_request && !tx_busy) begin
                    send      = 1'b1;
                    send_data = HS_ACK;
                end
                if (tag_seen) begin
                    tag_load   = 1'b1;
                    next_state = RX_LOAD_TAG;
                end else if (timer >= TIMER_W'(HS_CYCLES)) begin
                    next_state = IDLE;
                end
            end
            RX_LOAD_TAG: begin
                // Stalls here while the receive queue is full
                rx_queue.push_data = tag_bytes[2'd3 - tag_index];
                if (!rx_queue.full) begin
                    rx_queue.push = 1'b1;
                    tag_advance   = 1'b1;
                    if (tag_index == 2'd3) begin
                        next_state = RX_RECEIVE;
                    end
                end
            end
            RX_RECEIVE: begin
                if (byte_count == COUNT_W'(MAX_RX_BYTES)) begin
                    next_state = IDLE;
                end else if (timer >= TIMER_W'(SILENCE_CYCLES)) begin
                    next_state = IDLE;
                end else if (rx_valid) begin
                    // Bytes are dropped, but still counted, when the queue is full
                    timer_clear   = 1'b1;
                    count_inc     = 1'b1;
                    rx_queue.push = !rx_queue.full;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase

        if (next_state != state) begin
            timer_clear = 1'b1;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            timer       <= '0;
            byte_count  <= '0;
            tag_index   <= '0;
            tag_latched <= TAG_START;
        end else begin
            state <= next_state;

            if (timer_clear) begin
                timer <= '0;
            end else if (timer != TIMER_W'(TIMER_MAX)) begin
                timer <= timer + 1'b1;
            end

            if (state != RX_RECEIVE) begin
                byte_count <= '0;
            end else if (count_inc) begin
                byte_count <= byte_count + 1'b1;
            end

            if (state != RX_LOAD_TAG) begin
                tag_index <= '0;
            end else if (tag_advance) begin
                tag_index <= tag_index + 1'b1;
            end

            if (tag_load) begin
                tag_latched <= tag_kind;
            end
        end
    end

endmodule

`default_nettype wire

/* design/laser_link_top.sv */
`timescale 1ns/10ps
`default_nettype none

module laser_link_top
    import laser_link_pkg::*;
#(
    parameter int CLOCKS_PER_BIT  = 16,
    parameter int FIFO_DEPTH      = 16,
    parameter int MAX_RX_BYTES    = 1024,
    parameter int HS_TIMEOUT_BITS = 1024
) (
    input  logic       clock,
    input  logic       reset,
    input  link_byte_t host_in_data,
    input  logic       host_in_valid,
    output logic       host_in_full,
    output link_byte_t host_out_data,
    output logic       host_out_valid,
    input  logic       host_out_read,
    output logic       laser_tx,
    input  logic       laser_rx
);

    logic       send;
    link_byte_t send_data;
    logic       tx_busy;
    logic       tx_done;
    link_byte_t rx_data;
    logic       rx_valid;
    logic       tag_seen;
    tag_t       tag_kind;

    byte_queue_if tx_queue ();
    byte_queue_if rx_queue ();

    // Host side of both queues
    assign tx_queue.push      = host_in_valid;
    assign tx_queue.push_data = host_in_data;
    assign host_in_full       = tx_queue.full;
    assign rx_queue.pop       = host_out_read;
    assign host_out_data      = rx_queue.pop_data;
    assign host_out_valid     = !rx_queue.empty;

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo_i (
        .clock (clock),
        .reset (reset),
        .queue (tx_queue)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo_i (
        .clock (clock),
        .reset (reset),
        .queue (rx_queue)
    );

    laser_serializer #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) laser_serializer_i (
        .clock     (clock),
        .reset     (reset),
        .send      (send),
        .data      (send_data),
        .busy      (tx_busy),
        .done      (tx_done),
        .laser_out (laser_tx)
    );

    laser_deserializer #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) laser_deserializer_i (
        .clock    (clock),
        .reset    (reset),
        .laser_in (laser_rx),
        .data     (rx_data),
        .valid    (rx_valid)
    );

    frame_tag_detector frame_tag_detector_i (
        .clock    (clock),
        .reset    (reset),
        .data     (rx_data),
        .valid    (rx_valid),
        .tag_seen (tag_seen),
        .tag_kind (tag_kind)
    );

    link_controller #(
        .CLOCKS_PER_BIT  (CLOCKS_PER_BIT),
        .MAX_RX_BYTES    (MAX_RX_BYTES),
        .HS_TIMEOUT_BITS (HS_TIMEOUT_BITS)
    ) link_controller_i (
        .clock     (clock),
        .reset     (reset),
        .tx_queue  (tx_queue),
        .rx_queue  (rx_queue),
        .send      (send),
        .send_data (send_data),
        .tx_busy   (tx_busy),
        .tx_done   (tx_done),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .tag_seen  (tag_seen),
        .tag_kind  (tag_kind)
    );

endmodule

`default_nettype wire

/* tests/laser_link_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module laser_link_sva (
    input wire logic clock,
    input wire logic reset,
    input wire logic laser_tx,
    input wire logic send,
    input wire logic tx_busy,
    input wire logic host_out_valid,
    input wire logic rx_push
);

    int failures = 0;

    // Line idles high while held in reset
    tx_high_in_reset: assert property (@(posedge clock) reset |-> laser_tx)
        else begin
            failures++;
            $error("laser_tx low during reset");
        end

    no_send_while_busy: assert property (
        @(posedge clock) disable iff (reset) send |-> !tx_busy
    ) else begin
        failures++;
        $error("send issued while the serializer is busy");
    end

    // A byte shows up only after a push into the receive queue
    valid_needs_data: assert property (
        @(posedge clock) disable iff (reset)
        $rose(host_out_valid) |-> $past(rx_push)
    ) else begin
        failures++;
        $error("host_out_valid rose without a push into the receive queue");
    end

endmodule

bind laser_link_top laser_link_sva laser_link_sva_i (
    .clock          (clock),
    .reset          (reset),
    .laser_tx       (laser_tx),
    .send           (send),
    .tx_busy        (tx_busy),
    .host_out_valid (host_out_valid),
    .rx_push        (rx_queue.push)
);

`default_nettype wire

/* tests/laser_link_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module laser_link_tb
    import laser_link_pkg::*;
();

    localparam int BIT_CLOCKS   = 16;
    localparam int EDGE_TIMEOUT = 60 * BIT_CLOCKS;

    logic       clock;
    logic       reset;
    link_byte_t host_in_data;
    logic       host_in_valid;
    logic       host_in_full;
    link_byte_t host_out_data;
    logic       host_out_valid;
    logic       host_out_read;
    logic       laser_tx;
    logic       laser_rx;

    int error_count;
    int check_count;
    int seed;

    laser_link_top #(
        .CLOCKS_PER_BIT  (BIT_CLOCKS),
        .MAX_RX_BYTES    (8),
        .HS_TIMEOUT_BITS (64)
    ) laser_link_top_i (
        .clock          (clock),
        .reset          (reset),
        .host_in_data   (host_in_data),
        .host_in_valid  (host_in_valid),
        .host_in_full   (host_in_full),
        .host_out_data  (host_out_data),
        .host_out_valid (host_out_valid),
        .host_out_read  (host_out_read),
        .laser_tx       (laser_tx),
        .laser_rx       (laser_rx)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic check_value(input logic [7:0] got, input logic [7:0] exp,
                               input string what);
        check_count++;
        assert (got == exp) else begin
            error_count++;
            $display("ERR %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        $display("Timeout at %0t ns while waiting for %s", $time, what);
    endtask

    // Payload bytes avoid HS_REQUEST so an idle controller ignores them
    task automatic draw_byte(output link_byte_t b);
        int value;
        value = $random(seed);
        while (value[7:0] == HS_REQUEST) begin
            value = $random(seed);
        end
        b = value[7:0];
    endtask

    task automatic push_host(input link_byte_t b);
        host_in_data  = b;
        host_in_valid = 1'b1;
        next_cycle();
        host_in_valid = 1'b0;
    endtask

    task automatic read_host(input link_byte_t exp);
        int n;
        n = 0;
        while (!host_out_valid && n < EDGE_TIMEOUT) begin
            next_cycle();
            n++;
        end
        assert (host_out_valid) else report_timeout("a byte in the receive queue");
        if (host_out_valid) begin
            check_value(host_out_data, exp, "host byte");
            host_out_read = 1'b1;
            next_cycle();
            host_out_read = 1'b0;
        end
    endtask

    // Far end transmitter with data bits LSB first
    task automatic line_send(input link_byte_t b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            laser_rx = frame[i];
            repeat (BIT_CLOCKS) next_cycle();
        end
    endtask

    task automatic send_word(input logic [31:0] word);
        int n;
        for (n = 3; n >= 0; n--) begin
            line_send(word[8*n +: 8]);
        end
    endtask

    // Far end receiver returns at the middle of the stop bit
    task automatic decode_tx(output link_byte_t b, output logic ok);
        int n;
        int i;
        b = '0;
        n = 0;
        while (laser_tx && n < EDGE_TIMEOUT) begin
            next_cycle();
            n++;
        end
        ok = !laser_tx;
        assert (ok) else report_timeout("a start bit on laser_tx");
        if (ok) begin
            repeat (BIT_CLOCKS / 2) next_cycle();
            check_value(8'(laser_tx), 8'h00, "laser_tx start bit");
            for (i = 0; i < 8; i++) begin
                repeat (BIT_CLOCKS) next_cycle();
                b[i] = laser_tx;
            end
            repeat (BIT_CLOCKS) next_cycle();
            check_value(8'(laser_tx), 8'h01, "laser_tx stop bit");
        end
    endtask

    task automatic wait_line_quiet(input int bits);
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < bits * BIT_CLOCKS && n < 200 * BIT_CLOCKS) begin
            next_cycle();
            quiet = laser_tx ? quiet + 1 : 0;
            n++;
        end
        assert (quiet >= bits * BIT_CLOCKS) else report_timeout("a quiet laser_tx line");
    endtask

    task automatic expect_no_output(input int bits);
        int   n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < bits * BIT_CLOCKS && !seen; n++) begin
            next_cycle();
            seen = host_out_valid;
        end
        check_value(8'(seen), 8'h00, "unexpected receive queue byte");
    endtask

    task automatic far_end_handshake();
        link_byte_t reply;
        logic       ok;
        fork
            line_send(HS_REQUEST);
            decode_tx(reply, ok);
        join
        if (ok) begin
            check_value(reply, HS_ACK, "handshake reply");
        end
    endtask

    task automatic run_burst(input logic [31:0] word, input int payload_count,
                             input int keep_count);
        link_byte_t payload [$];
        link_byte_t b;
        int         n;
        far_end_handshake();
        send_word(word);
        for (n = 0; n < payload_count; n++) begin
            draw_byte(b);
            payload.push_back(b);
            line_send(b);
        end
        // Tag word comes first in most significant byte order
        for (n = 3; n >= 0; n--) begin
            read_host(word[8*n +: 8]);
        end
        for (n = 0; n < keep_count; n++) begin
            read_host(payload[n]);
        end
        expect_no_output(16);
    endtask

    task automatic idle_after_reset();
        int   n;
        logic tx_low;
        tx_low = 1'b0;
        for (n = 0; n < 4 * BIT_CLOCKS; n++) begin
            next_cycle();
            tx_low = tx_low | !laser_tx;
        end
        check_value(8'(tx_low), 8'h00, "laser_tx low after reset");
        check_value(8'(host_out_valid), 8'h00, "host_out_valid after reset");
        check_value(8'(host_in_full), 8'h00, "host_in_full after reset");
    endtask

    task automatic transmit_queued_bytes();
        link_byte_t sent [$];
        link_byte_t seen [$];
        link_byte_t b;
        logic       ok;
        int         requests;
        int         frames;
        int         n;
        int         i;
        requests = 0;
        frames   = 0;
        for (n = 0; n < 3; n++) begin
            draw_byte(b);
            sent.push_back(b);
            push_host(b);
        end
        ok = 1'b1;
        fork
            begin
                while (ok && seen.size() < 3 && frames < 40) begin
                    decode_tx(b, ok);
                    frames++;
                    if (ok && b == HS_REQUEST && seen.size() == 0) begin
                        requests++;
                    end else if (ok) begin
                        seen.push_back(b);
                    end
                end
            end
            begin
                // Acknowledge only once the request has repeated
                n = 0;
                while (requests < 2 && n < EDGE_TIMEOUT) begin
                    next_cycle();
                    n++;
                end
                assert (requests >= 2) else report_timeout("repeated handshake requests");
                line_send(HS_ACK);
            end
        join
        check_value(8'(seen.size()), 8'd3, "transmitted byte count");
        for (i = 0; i < seen.size() && i < 3; i++) begin
            check_value(seen[i], sent[i], "transmitted byte");
        end
        wait_line_quiet(20);
    endtask

    task automatic receive_start_burst();
        run_burst(32'hC1C2C3C4, 5, 5);
    endtask

    task automatic receive_over_limit();
        run_burst(32'hA1A2A3A4, 11, 8);
    endtask

    task automatic recover_from_broken_tag();
        far_end_handshake();
        line_send(8'hC1);
        line_send(8'hC2);
        line_send(8'hFF);
        // Long enough to pass the handshake timeout
        expect_no_output(40);
        // Back in idle a tag without a handshake is ignored
        send_word(32'hB1B2B3B4);
        expect_no_output(16);
        run_burst(32'hB1B2B3B4, 0, 0);
    endtask

    initial begin
        int sva_failures;
        seed          = 13654;
        error_count   = 0;
        check_count   = 0;
        reset         = 1'b1;
        host_in_data  = '0;
        host_in_valid = 1'b0;
        host_out_read = 1'b0;
        laser_rx      = 1'b1;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        idle_after_reset();
        transmit_queued_bytes();
        receive_start_burst();
        receive_over_limit();
        recover_from_broken_tag();

        sva_failures = laser_link_top_i.laser_link_sva_i.failures;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, sva_failures);
        if (error_count == 0 && sva_failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
design/laser_link_pkg.sv
design/byte_queue_if.sv
design/byte_fifo.sv
design/laser_serializer.sv
design/laser_deserializer.sv
design/frame_tag_detector.sv
design/link_controller.sv
design/laser_link_top.sv
tests/laser_link_sva.sv
tests/laser_link_tb.sv
